// ==== compile.f ====
design/msx_glue_pkg.sv
design/sd_route.sv
design/tape_control.sv
design/video_setup.sv
design/msx_glue_top.sv
test/tb_msx_glue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the MSX glue testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module tb_msx_glue -f compile.f -Mdir obj_dir -o sim_msx_glue

./obj_dir/sim_msx_glue | tee sim.log

if grep -Fxq '** PASS **' sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

// ==== test/msx_glue_golden.txt ====
// Every row: kind c1..c11 (hex), unused columns are 0
// 1 SD:    strobe size_hi size_lo spi_clk spi_mosi sd_miso vsd_miso | cs sck mosi miso
// 2 LED:   lit led_user, lit led_disk[0]
// 3 tape:  download index tape_rewind motor | play rewind
// 4 audio: expected cas_audio_in per {cas_src,file,adc,adc_act}, one bit each
// 5 DDR3:  loader_request loader_rd loader_addr cas_rd cas_addr | rd addr
// 6 video: width height forced aspect scale_fx | arx ary vga_sl hq2x sd crop_next
1 1 0 1000 1 1 0 1 1 0 0 1
1 0 0 0 1 1 1 0 1 0 0 0
1 1 0 0 1 1 0 1 0 1 1 0
1 0 0 0 0 1 1 0 0 0 1 1
2 0 1 0 0 0 0 0 0 0 0 0
1 1 1 0 0 0 0 0 1 0 0 0
2 1 0 0 0 0 0 0 0 0 0 0
3 1 1 0 0 0 0 0 0 0 0 0
3 0 1 0 0 0 0 0 0 0 0 0
3 0 1 0 0 0 0 0 0 0 0 0
3 1 5 0 0 0 1 0 0 0 0 0
3 1 5 0 0 0 1 0 0 0 0 0
3 0 5 0 0 0 0 0 0 0 0 0
3 0 5 0 0 1 0 0 0 0 0 0
3 1 1 0 0 1 0 0 0 0 0 0
3 0 1 0 1 0 0 0 0 0 0 0
3 0 1 1 1 0 1 0 0 0 0 0
3 0 1 0 0 1 0 0 0 0 0 0
4 88f0 0 0 0 0 0 0 0 0 0 0
5 1 1 0abcdef 0 1234560 1 0abcdef 0 0 0 0
5 0 1 0abcdef 0 1234560 0 1234560 0 0 0 0
5 1 0 fffffff 1 0000040 0 fffffff 0 0 0 0
5 0 0 fffffff 1 0000040 1 0000040 0 0 0 0
6 780 438 0 0 0 4 3 0 0 0 d8
6 780 438 0 1 1 0 0 0 1 1 0
6 780 438 0 2 2 1 0 1 0 1 0
6 780 438 0 3 3 2 0 2 0 1 0
6 780 438 0 0 4 4 3 3 0 1 0
6 780 438 1 1 0 0 0 0 0 1 0
6 500 2d0 0 2 0 1 0 0 0 0 0
6 780 2d0 0 0 0 4 3 0 0 0 0
6 780 438 0 3 0 2 0 0 0 0 d8

// ==== test/tb_msx_glue.sv ====
// ============================================================
// MSX glue testbench
// Replays golden vectors through the SD, cassette, DDR3 and
// video paths and compares every output with the vector
// ============================================================

`timescale 1ns/1ns

module tb_msx_glue;

   import msx_glue_pkg::*;

   localparam int ACT_HOLD = 64;
   localparam int NW       = 12;
   localparam int MAX_ROWS = 64;

   logic         clock_bus;
   logic         arst_n;
   logic         img_mounted_sd;
   img_size_t    img_size;
   logic         spi_clk;
   logic         spi_mosi;
   logic         sd_miso;
   logic         vsd_miso;
   logic         sd_cs;
   logic         sd_sck;
   logic         sd_mosi;
   logic         spi_miso;
   logic         led_user;
   logic [1:0]   led_disk;
   logic         ioctl_download;
   ioctl_index_t ioctl_index;
   logic         tape_rewind;
   logic         motor;
   cas_src_t     cas_src;
   logic         cas_file_bit;
   logic         tape_adc;
   logic         tape_adc_act;
   logic         loader_request;
   logic         loader_rd;
   logic         cas_rd;
   ddr_addr_t    loader_addr;
   ddr_addr_t    cas_addr;
   logic         play;
   logic         rewind;
   logic         cas_audio_in;
   logic         ddr3_rd;
   ddr_addr_t    ddr3_addr;
   video_dim_t   hdmi_width;
   video_dim_t   hdmi_height;
   logic         forced_scandoubler;
   aspect_t      aspect;
   scale_fx_t    scale_fx;
   video_dim_t   video_arx;
   video_dim_t   video_ary;
   video_dim_t   crop_size;
   logic [1:0]   vga_sl;
   logic         hq2x;
   logic         scandoubler;

   logic [31:0]  gold [0:NW*MAX_ROWS-1];
   int           errors      = 0;
   int           checks      = 0;
   int           cycle_cnt   = 0;
   int           cycle_limit = 2000;
   int           nrows;
   int           b;
   video_dim_t   crop_prev   = '0;

   msx_glue_top #(
      .ACT_HOLD_CYCLES (ACT_HOLD)
   ) i_dut (.*);

   initial begin
      clock_bus = 1'b0;
      forever #10 clock_bus = ~clock_bus;
   end

   // ============================================================
   // Compare tasks and run end
   // ============================================================
   task automatic check_bit(input string name, input logic got, input logic want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
      end
   endtask

   task automatic check_vec2(input string name, input logic [1:0] got,
                             input logic [1:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
      end
   endtask

   task automatic check_dim(input string name, input video_dim_t got,
                            input video_dim_t want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
      end
   endtask

   task automatic check_addr(input string name, input ddr_addr_t got,
                             input ddr_addr_t want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
      end
   endtask

   task automatic report_and_finish(input bit timed_out);
      $display("Checks: %0d  errors: %0d", checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   endtask

   always @(posedge clock_bus) begin
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout: run still busy after %0d cycles", cycle_cnt);
         report_and_finish(1'b1);
      end
   end

   // ============================================================
   // Row handlers, one per kind tag
   // ============================================================
   // Strobe or hold, then check pin routing a cycle later
   task automatic route_sd(input int r);
      @(negedge clock_bus);
      img_mounted_sd = gold[r+1][0];
      img_size       = {gold[r+2], gold[r+3]};
      spi_clk        = gold[r+4][0];
      spi_mosi       = gold[r+5][0];
      sd_miso        = gold[r+6][0];
      vsd_miso       = gold[r+7][0];
      @(negedge clock_bus);
      img_mounted_sd = 1'b0;
      #5;
      check_bit("sd_cs", sd_cs, gold[r+8][0]);
      check_bit("sd_sck", sd_sck, gold[r+9][0]);
      check_bit("sd_mosi", sd_mosi, gold[r+10][0]);
      check_bit("spi_miso", spi_miso, gold[r+11][0]);
   endtask

   // One MOSI toggle lights the LED from edge 2 through edge 65
   task automatic hold_leds(input int r);
      repeat (ACT_HOLD + 4) @(negedge clock_bus);
      #5;
      check_bit("led_user", led_user, 1'b0);
      check_vec2("led_disk", led_disk, 2'b10);
      @(negedge clock_bus);
      spi_mosi = ~spi_mosi;
      repeat (2) @(negedge clock_bus);
      #5;
      check_bit("led_user", led_user, gold[r+1][0]);
      check_vec2("led_disk", led_disk, {1'b1, gold[r+2][0]});
      repeat (ACT_HOLD - 2) @(negedge clock_bus);
      #5;
      check_bit("led_user", led_user, gold[r+1][0]);
      check_vec2("led_disk", led_disk, {1'b1, gold[r+2][0]});
      repeat (2) @(negedge clock_bus);
      #5;
      check_bit("led_user", led_user, 1'b0);
      check_vec2("led_disk", led_disk, 2'b10);
   endtask

   task automatic step_tape(input int r);
      @(negedge clock_bus);
      ioctl_download = gold[r+1][0];
      ioctl_index    = gold[r+2][15:0];
      tape_rewind    = gold[r+3][0];
      motor          = gold[r+4][0];
      #5;
      check_bit("play", play, gold[r+5][0]);
      check_bit("rewind", rewind, gold[r+6][0]);
   endtask

   // Bit c of the mask is the expected output for input combo c
   task automatic sweep_audio(input int r);
      logic [3:0] combo;
      for (int c = 0; c < 16; c++) begin
         combo = c[3:0];
         @(negedge clock_bus);
         cas_src      = cas_src_t'(combo[3]);
         cas_file_bit = combo[2];
         tape_adc     = combo[1];
         tape_adc_act = combo[0];
         #5;
         check_bit("cas_audio_in", cas_audio_in, gold[r+1][c]);
      end
   endtask

   task automatic share_ddr(input int r);
      @(negedge clock_bus);
      loader_request = gold[r+1][0];
      loader_rd      = gold[r+2][0];
      loader_addr    = gold[r+3][27:0];
      cas_rd         = gold[r+4][0];
      cas_addr       = gold[r+5][27:0];
      #5;
      check_bit("ddr3_rd", ddr3_rd, gold[r+6][0]);
      check_addr("ddr3_addr", ddr3_addr, gold[r+7][27:0]);
   endtask

   // Immediate decode, while the crop still shows the previous setting
   task automatic decode_video(input int r);
      @(negedge clock_bus);
      hdmi_width         = gold[r+1][11:0];
      hdmi_height        = gold[r+2][11:0];
      forced_scandoubler = gold[r+3][0];
      aspect             = aspect_t'(gold[r+4][1:0]);
      scale_fx           = gold[r+5][2:0];
      #5;
      check_dim("video_arx", video_arx, gold[r+6][11:0]);
      check_dim("video_ary", video_ary, gold[r+7][11:0]);
      check_vec2("vga_sl", vga_sl, gold[r+8][1:0]);
      check_bit("hq2x", hq2x, gold[r+9][0]);
      check_bit("scandoubler", scandoubler, gold[r+10][0]);
      check_dim("crop_size", crop_size, crop_prev);
      @(negedge clock_bus);
      #5;
      check_dim("crop_size", crop_size, gold[r+11][11:0]);
      crop_prev = gold[r+11][11:0];
   endtask

   // ============================================================
   // Main sequence
   // ============================================================
   initial begin
      arst_n             = 1'b0;
      img_mounted_sd     = 1'b0;
      img_size           = '0;
      spi_clk            = 1'b0;
      spi_mosi           = 1'b0;
      sd_miso            = 1'b0;
      vsd_miso           = 1'b0;
      ioctl_download     = 1'b0;
      ioctl_index        = '0;
      tape_rewind        = 1'b0;
      motor              = 1'b0;
      cas_src            = CAS_SRC_FILE;
      cas_file_bit       = 1'b0;
      tape_adc           = 1'b0;
      tape_adc_act       = 1'b0;
      loader_request     = 1'b0;
      loader_rd          = 1'b0;
      cas_rd             = 1'b0;
      loader_addr        = '0;
      cas_addr           = '0;
      hdmi_width         = '0;
      hdmi_height        = '0;
      forced_scandoubler = 1'b0;
      aspect             = ASPECT_ORIGINAL;
      scale_fx           = '0;

      // Unread rows stay zero and end the vector list
      for (int i = 0; i < NW * MAX_ROWS; i++) begin
         gold[i] = '0;
      end
      $readmemh("test/msx_glue_golden.txt", gold);
      nrows = 0;
      while (nrows < MAX_ROWS && gold[nrows*NW] != '0) begin
         nrows++;
      end
      cycle_limit = 20 * nrows + 2000;
      if (nrows == 0) begin
         errors++;
         $display("Golden file holds no vectors");
      end

      repeat (16) @(negedge clock_bus);
      arst_n = 1'b1;
      #5;
      check_bit("sd_cs", sd_cs, 1'b0);
      check_bit("led_user", led_user, 1'b0);
      check_vec2("led_disk", led_disk, 2'b10);
      check_bit("play", play, 1'b0);
      check_bit("rewind", rewind, 1'b0);
      check_dim("crop_size", crop_size, '0);

      for (int r = 0; r < nrows; r++) begin
         b = r * NW;
         case (gold[b][3:0])
            4'h1: route_sd(b);
            4'h2: hold_leds(b);
            4'h3: step_tape(b);
            4'h4: sweep_audio(b);
            4'h5: share_ddr(b);
            4'h6: decode_video(b);
            default: begin
               errors++;
               $display("Golden row %0d has unknown kind tag %0h", r, gold[b]);
            end
         endcase
      end
      report_and_finish(1'b0);
   end

endmodule

// ==== design/msx_glue_top.sv ====
// ============================================================
// MSX glue top level
// SD routing, cassette control and video setup around the
// MSX core
// ============================================================

`timescale 1ns/1ns

module msx_glue_top #(
   parameter int ACT_HOLD_CYCLES = 1_000_000
) (
   input  logic                       clock_bus,
   input  logic                       arst_n,

   // SD card
   input  logic                       img_mounted_sd,
   input  msx_glue_pkg::img_size_t    img_size,
   input  logic                       spi_clk,
   input  logic                       spi_mosi,
   input  logic                       sd_miso,
   input  logic                       vsd_miso,
   output logic                       sd_cs,
   output logic                       sd_sck,
   output logic                       sd_mosi,
   output logic                       spi_miso,
   output logic                       led_user,
   output logic [1:0]                 led_disk,

   // Cassette and DDR3
   input  logic                       ioctl_download,
   input  msx_glue_pkg::ioctl_index_t ioctl_index,
   input  logic                       tape_rewind,
   input  logic                       motor,
   input  msx_glue_pkg::cas_src_t     cas_src,
   input  logic                       cas_file_bit,
   input  logic                       tape_adc,
   input  logic                       tape_adc_act,
   input  logic                       loader_request,
   input  logic                       loader_rd,
   input  logic                       cas_rd,
   input  msx_glue_pkg::ddr_addr_t    loader_addr,
   input  msx_glue_pkg::ddr_addr_t    cas_addr,
   output logic                       play,
   output logic                       rewind,
   output logic                       cas_audio_in,
   output logic                       ddr3_rd,
   output msx_glue_pkg::ddr_addr_t    ddr3_addr,

   // Video
   input  msx_glue_pkg::video_dim_t   hdmi_width,
   input  msx_glue_pkg::video_dim_t   hdmi_height,
   input  logic                       forced_scandoubler,
   input  msx_glue_pkg::aspect_t      aspect,
   input  msx_glue_pkg::scale_fx_t    scale_fx,
   output msx_glue_pkg::video_dim_t   video_arx,
   output msx_glue_pkg::video_dim_t   video_ary,
   output msx_glue_pkg::video_dim_t   crop_size,
   output logic [1:0]                 vga_sl,
   output logic                       hq2x,
   output logic                       scandoubler
);

   sd_route #(
      .ACT_HOLD_CYCLES (ACT_HOLD_CYCLES)
   ) i_sd_route (
      .clock_bus      (clock_bus),
      .arst_n         (arst_n),
      .img_mounted_sd (img_mounted_sd),
      .img_size       (img_size),
      .spi_clk        (spi_clk),
      .spi_mosi       (spi_mosi),
      .sd_miso        (sd_miso),
      .vsd_miso       (vsd_miso),
      .sd_cs          (sd_cs),
      .sd_sck         (sd_sck),
      .sd_mosi        (sd_mosi),
      .spi_miso       (spi_miso),
      .led_user       (led_user),
      .led_disk       (led_disk)
   );

   tape_control i_tape_control (
      .clock_bus      (clock_bus),
      .arst_n         (arst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .tape_rewind    (tape_rewind),
      .motor          (motor),
      .cas_src        (cas_src),
      .cas_file_bit   (cas_file_bit),
      .tape_adc       (tape_adc),
      .tape_adc_act   (tape_adc_act),
      .loader_request (loader_request),
      .loader_rd      (loader_rd),
      .cas_rd         (cas_rd),
      .loader_addr    (loader_addr),
      .cas_addr       (cas_addr),
      .play           (play),
      .rewind         (rewind),
      .cas_audio_in   (cas_audio_in),
      .ddr3_rd        (ddr3_rd),
      .ddr3_addr      (ddr3_addr)
   );

   video_setup i_video_setup (
      .clock_bus          (clock_bus),
      .arst_n             (arst_n),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .forced_scandoubler (forced_scandoubler),
      .aspect             (aspect),
      .scale_fx           (scale_fx),
      .video_arx          (video_arx),
      .video_ary          (video_ary),
      .crop_size          (crop_size),
      .vga_sl             (vga_sl),
      .hq2x               (hq2x),
      .scandoubler        (scandoubler)
   );

endmodule

// ==== design/video_setup.sv ====
// ============================================================
// Video setup
// Aspect ratio, scanline and scaler decode plus the
// registered 1080p to 216p crop
// ============================================================

`timescale 1ns/1ns

module video_setup (
   input  logic                     clock_bus,
   input  logic                     arst_n,
   input  msx_glue_pkg::video_dim_t hdmi_width,
   input  msx_glue_pkg::video_dim_t hdmi_height,
   input  logic                     forced_scandoubler,
   input  msx_glue_pkg::aspect_t    aspect,
   input  msx_glue_pkg::scale_fx_t  scale_fx,
   output msx_glue_pkg::video_dim_t video_arx,
   output msx_glue_pkg::video_dim_t video_ary,
   output msx_glue_pkg::video_dim_t crop_size,
   output logic [1:0]               vga_sl,
   output logic                     hq2x,
   output logic                     scandoubler
);

   import msx_glue_pkg::*;

   logic en216p;

   // ============================================================
   // Aspect ratio
   // ============================================================
   always_comb begin
      if (aspect == ASPECT_ORIGINAL) begin
         video_arx = ORIG_ARX;
         video_ary = ORIG_ARY;
      end else begin
         // Small index values select the scaler's stored ratios
         video_arx = video_dim_t'(aspect) - video_dim_t'(1);
         video_ary = '0;
      end
   end

   // ============================================================
   // Scandoubler effects
   // ============================================================
   assign vga_sl      = (scale_fx != '0) ? 2'(scale_fx - 3'd1) : 2'd0;
   assign hq2x        = (scale_fx == 3'd1);
   assign scandoubler = (scale_fx != '0) | forced_scandoubler;

   // Crop only for plain 1080p output
   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         en216p <= 1'b0;
      end else begin
         en216p <= (hdmi_width == FULLHD_WIDTH) &&
                   (hdmi_height == FULLHD_HEIGHT) &&
                   !forced_scandoubler &&
                   (scale_fx == '0);
      end
   end

   assign crop_size = en216p ? CROP_216P : '0;

endmodule

// ==== design/tape_control.sv ====
// ============================================================
// Cassette control
// Tape load latch, play and rewind, audio source select and
// DDR3 read port sharing with the ROM loader
// ============================================================

`timescale 1ns/1ns

module tape_control (
   input  logic                       clock_bus,
   input  logic                       arst_n,
   input  logic                       ioctl_download,
   input  msx_glue_pkg::ioctl_index_t ioctl_index,
   input  logic                       tape_rewind,
   input  logic                       motor,
   input  msx_glue_pkg::cas_src_t     cas_src,
   input  logic                       cas_file_bit,
   input  logic                       tape_adc,
   input  logic                       tape_adc_act,
   input  logic                       loader_request,
   input  logic                       loader_rd,
   input  logic                       cas_rd,
   input  msx_glue_pkg::ddr_addr_t    loader_addr,
   input  msx_glue_pkg::ddr_addr_t    cas_addr,
   output logic                       play,
   output logic                       rewind,
   output logic                       cas_audio_in,
   output logic                       ddr3_rd,
   output msx_glue_pkg::ddr_addr_t    ddr3_addr
);

   import msx_glue_pkg::*;

   tape_state_t tape_state;
   logic        cas_dl;
   logic        cas_dl_q;

   // CAS file download in progress
   assign cas_dl = ioctl_download & (ioctl_index[5:0] == CAS_IOCTL_INDEX);

   // ============================================================
   // Load latch
   // ============================================================
   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         cas_dl_q   <= 1'b0;
         tape_state <= TAPE_EMPTY;
      end else begin
         cas_dl_q <= cas_dl;
         // Falling edge of the download marks the tape as loaded
         if (cas_dl_q && !cas_dl) begin
            tape_state <= TAPE_LOADED;
         end
      end
   end

   // Player runs while the motor line is low
   assign play   = (tape_state == TAPE_LOADED) & ~motor;
   assign rewind = tape_rewind | cas_dl | ~arst_n;

   // Audio input source
   always_comb begin
      if (cas_src == CAS_SRC_FILE) begin
         cas_audio_in = cas_file_bit;
      end else begin
         cas_audio_in = tape_adc & tape_adc_act;
      end
   end

   // ============================================================
   // DDR3 port sharing with loader priority
   // ============================================================
   assign ddr3_addr = loader_request ? loader_addr : cas_addr;
   assign ddr3_rd   = loader_request ? loader_rd   : cas_rd;

   a_play_needs_tape : assert property (
      @(posedge clock_bus) disable iff (!arst_n)
      play |-> (tape_state == TAPE_LOADED)
   );

endmodule

// ==== design/sd_route.sv ====
// ============================================================
// SD card routing
// Selects the virtual SD card or the physical SD pins and
// drives the disk and user activity LEDs
// ============================================================

`timescale 1ns/1ns

module sd_route #(
   parameter int ACT_HOLD_CYCLES = 1_000_000
) (
   input  logic                    clock_bus,
   input  logic                    arst_n,
   input  logic                    img_mounted_sd,
   input  msx_glue_pkg::img_size_t img_size,
   input  logic                    spi_clk,
   input  logic                    spi_mosi,
   input  logic                    sd_miso,
   input  logic                    vsd_miso,
   output logic                    sd_cs,
   output logic                    sd_sck,
   output logic                    sd_mosi,
   output logic                    spi_miso,
   output logic                    led_user,
   output logic [1:0]              led_disk
);

   import msx_glue_pkg::*;

   localparam int CNT_W = $clog2(ACT_HOLD_CYCLES + 1);
   localparam logic [CNT_W-1:0] HOLD_MAX = CNT_W'(ACT_HOLD_CYCLES);

   logic             vsd_sel;
   logic             old_mosi;
   logic             old_miso;
   logic [CNT_W-1:0] act_cnt;
   logic             sd_act;
   logic             spi_toggle;

   // Virtual card selected by any nonzero mounted image
   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted_sd) begin
         vsd_sel <= |img_size;
      end
   end

   // Pins are parked while the virtual card owns the bus
   assign sd_cs    = vsd_sel;
   assign sd_sck   = spi_clk & ~vsd_sel;
   assign sd_mosi  = spi_mosi & ~vsd_sel;
   assign spi_miso = vsd_sel ? vsd_miso : sd_miso;

   // ============================================================
   // Activity hold timer
   // ============================================================
   assign spi_toggle = (old_mosi ^ spi_mosi) | (old_miso ^ spi_miso);

   always_ff @(posedge clock_bus or negedge arst_n) begin
      if (!arst_n) begin
         old_mosi <= 1'b0;
         old_miso <= 1'b0;
         act_cnt  <= HOLD_MAX;
         sd_act   <= 1'b0;
      end else begin
         old_mosi <= spi_mosi;
         old_miso <= spi_miso;
         sd_act   <= (act_cnt < HOLD_MAX);
         // Restart on any data edge, else count up to the hold
         if (spi_toggle) begin
            act_cnt <= '0;
         end else if (act_cnt < HOLD_MAX) begin
            act_cnt <= act_cnt + 1'b1;
         end
      end
   end

   // LED of the active medium
   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

   a_no_pin_clk_on_vsd : assert property (
      @(posedge clock_bus) disable iff (!arst_n)
      vsd_sel |-> !sd_sck
   );

endmodule

// ==== design/msx_glue_pkg.sv ====
// ============================================================
// MSX glue shared definitions
// Widths, setting enums and video constants used by the SD,
// cassette and video blocks
// ============================================================

package msx_glue_pkg;

   // ============================================================
   // Widths
   // ============================================================
   typedef logic [63:0] img_size_t;
   typedef logic [27:0] ddr_addr_t;
   typedef logic [15:0] ioctl_index_t;
   typedef logic [11:0] video_dim_t;

   // 0 none, 1 hq2x, 2..4 CRT scanlines
   typedef logic [2:0] scale_fx_t;

   // ============================================================
   // Setting enums
   // ============================================================
   typedef enum logic [1:0] {
      ASPECT_ORIGINAL = 2'd0,
      ASPECT_FULL     = 2'd1,
      ASPECT_ARC1     = 2'd2,
      ASPECT_ARC2     = 2'd3
   } aspect_t;

   typedef enum logic {
      CAS_SRC_FILE = 1'b0,
      CAS_SRC_ADC  = 1'b1
   } cas_src_t;

   typedef enum logic {
      TAPE_EMPTY  = 1'b0,
      TAPE_LOADED = 1'b1
   } tape_state_t;

   // Download slot of the CAS file in the low 6 bits of the index
   localparam logic [5:0] CAS_IOCTL_INDEX = 6'd5;

   // Video constants
   localparam video_dim_t FULLHD_WIDTH  = 12'd1920;
   localparam video_dim_t FULLHD_HEIGHT = 12'd1080;
   localparam video_dim_t CROP_216P     = 12'd216;
   localparam video_dim_t ORIG_ARX      = 12'd4;
   localparam video_dim_t ORIG_ARY      = 12'd3;

endpackage
